// File: tb.f
verilog/board_pkg.sv
verilog/hps_reset_pkg.sv
verilog/key_debounce.sv
verilog/reset_pulse_stretch.sv
verilog/heartbeat.sv
verilog/fpga_glue_top.sv
test/tb_fpga_glue.sv

// File: Makefile
# Verilator build and run for the fabric glue testbench

VERILATOR ?= verilator
TOP       := tb_fpga_glue
FILELIST  := tb.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0 --Mdir $(BUILD_DIR)
PASS_MSG  := TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass if the run reports success"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: test/tb_fpga_glue.sv
// testbench for the fabric glue top level
// drives keys, switches, processor LED bits and reset requests into the DUT
// concurrent assertions watch the steady rules, procedural checks time the edges
// short debounce and blink times keep the run small
`timescale 1ns/1ps

module tb_fpga_glue;

  import board_pkg::*;
  import hps_reset_pkg::*;

  localparam int unsigned debounce_cycles   = 16;
  localparam int unsigned blink_half_period = 100;

  // ======================================================================
  // test lengths in clock cycles
  // ======================================================================
  localparam int unsigned n_glitch     = 40;
  localparam int unsigned glitch_gap   = 8;   // released cycles between glitches
  localparam int unsigned key_hold     = 40;
  localparam int unsigned n_event      = 200;
  localparam int unsigned glitch_total = n_glitch * (12 + glitch_gap + 1);
  localparam int unsigned key_total    = 2 * key_w * (key_hold + 2);
  localparam int unsigned pulse_total  = 6 * (debug_pulse_len + 16);  // upper bound
  localparam int unsigned event_total  = n_event + 3 * key_hold;
  localparam int unsigned test_cycles  = glitch_total + key_total + pulse_total + event_total;
  localparam int unsigned watchdog_cycles = 4 * test_cycles + 10000;  // wide margin

  logic        fpga_clk_50;
  logic        hps_fpga_reset_n;
  key_t        key;
  sw_t         sw;
  led_pio_t    led_pio;
  reset_req_t  reset_req;
  led_t        ledr;
  stm_events_t stm_hw_events;
  key_t        debounced_keys;
  logic        cold_reset_req_n;
  logic        warm_reset_req_n;
  logic        debug_reset_req_n;

  string       test_name;
  key_t        key_mask;       // keys allowed to leave released
  reset_req_t  quiet_mask;     // request outputs that must stay 1
  int unsigned hb_edges;       // clock edges since reset release
  int unsigned hb_phase;
  stm_events_t exp_events;
  reset_req_t  req_n_vec;      // debug, warm, cold
  int          assert_errors;
  int          check_errors;
  int          seed_draw;

  fpga_glue_top #(
    .debounce_cycles   (debounce_cycles),
    .blink_half_period (blink_half_period)
  ) dut_i (
    .fpga_clk_50       (fpga_clk_50),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .key               (key),
    .sw                (sw),
    .led_pio           (led_pio),
    .reset_req         (reset_req),
    .ledr              (ledr),
    .stm_hw_events     (stm_hw_events),
    .debounced_keys    (debounced_keys),
    .cold_reset_req_n  (cold_reset_req_n),
    .warm_reset_req_n  (warm_reset_req_n),
    .debug_reset_req_n (debug_reset_req_n)
  );

  initial
  begin
    fpga_clk_50 = 1'b0;
    forever #5 fpga_clk_50 = ~fpga_clk_50;   // 100 MHz sim clock, period only matters here
  end

  // ======================================================================
  // reference models and concurrent checks
  // ======================================================================
  always @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      hb_edges <= 0;
    end
    else
    begin
      hb_edges <= hb_edges + 1;
    end
  end

  assign hb_phase   = hb_edges / blink_half_period;  // led flips each whole half period
  assign req_n_vec  = {debug_reset_req_n, warm_reset_req_n, cold_reset_req_n};

  // event word built field by field, keys in the low bits
  always_comb
  begin
    exp_events                            = '0;   // pad bits on top stay zero
    exp_events[key_w-1:0]                 = debounced_keys;
    exp_events[key_w +: led_pio_w]        = led_pio;
    exp_events[key_w + led_pio_w +: sw_w] = sw;
  end

  assert property (@(posedge fpga_clk_50) stm_hw_events == exp_events)
  else
  begin
    assert_errors++;
    $display("Mismatch %s event word: expected %h actual %h", test_name,
             $sampled(exp_events), $sampled(stm_hw_events));
  end

  assert property (@(posedge fpga_clk_50) ledr[led_w-1:1] == led_pio)
  else
  begin
    assert_errors++;
    $display("Mismatch %s led bar: expected %h actual %h", test_name,
             $sampled(led_pio), $sampled(ledr[led_w-1:1]));
  end

  assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
                   ledr[0] == hb_phase[0])
  else
  begin
    assert_errors++;
    $display("Mismatch %s heartbeat: expected %0d actual %0d", test_name,
             $sampled(hb_phase[0]), $sampled(ledr[0]));
  end

  // keys outside key_mask stay released
  assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
                   (debounced_keys | key_mask) == '1)
  else
  begin
    assert_errors++;
    $display("Mismatch %s debounced keys: expected %b actual %b", test_name,
             $sampled(debounced_keys | key_mask), $sampled(debounced_keys));
  end

  assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
                   (req_n_vec | ~quiet_mask) == '1)
  else
  begin
    assert_errors++;
    $display("Mismatch %s idle request outputs: expected %b actual %b", test_name,
             $sampled(req_n_vec | ~quiet_mask), $sampled(req_n_vec));
  end

  // ======================================================================
  // procedural checks
  // ======================================================================
  task automatic check_value(input string what, input int expected, input int actual);
    assert (actual == expected)
    else
    begin
      check_errors++;
      $display("Mismatch %s %s: expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic check_window(input string what, input int actual, input int lo, input int hi);
    assert (actual >= lo && actual <= hi)
    else
    begin
      check_errors++;
      $display("Mismatch %s %s: expected %0d to %0d actual %0d", test_name, what, lo, hi,
               actual);
    end
  endtask

  // edge driven at the posedge just before the call
  task automatic expect_pulse(input string what, input int chan, input int len);
    int width;
    begin
      @(negedge fpga_clk_50);
      check_value({what, " before start"}, 1, int'(req_n_vec[chan]));
      @(negedge fpga_clk_50);
      check_value({what, " one cycle later"}, 0, int'(req_n_vec[chan]));
      width = 0;
      while (req_n_vec[chan] == 1'b0 && width < int'(2 * debug_pulse_len))
      begin
        width++;
        @(negedge fpga_clk_50);
      end
      check_value({what, " width"}, len, width);
    end
  endtask

  task automatic expect_idle(input string what, input int chan, input int cycles);
    repeat (cycles)
    begin
      @(negedge fpga_clk_50);
      check_value(what, 1, int'(req_n_vec[chan]));
    end
  endtask

  task automatic pulse_one(input string what, input int chan, input int len);
    quiet_mask       = '1;
    quiet_mask[chan] = 1'b0;
    @(posedge fpga_clk_50);
    reset_req[chan] <= 1'b1;
    expect_pulse(what, chan, len);
    @(posedge fpga_clk_50);
    reset_req[chan] <= 1'b0;
    expect_idle({what, " after drop"}, chan, 8);
    quiet_mask = '1;
  endtask

  // cycles from the driving edge until the output shows the level
  task automatic key_latency(input int idx, input logic level, output int lat);
    logic done;
    begin
      lat  = 0;
      done = 1'b0;
      while (!done)
      begin
        @(posedge fpga_clk_50);
        lat++;
        @(negedge fpga_clk_50);
        if (debounced_keys[idx] == level || lat >= int'(4 * debounce_cycles))
        begin
          done = 1'b1;
        end
      end
    end
  endtask

  task automatic press_and_release(input int idx);
    int lat;
    begin
      key_mask      = '0;
      key_mask[idx] = 1'b1;
      @(posedge fpga_clk_50);
      key[idx] <= 1'b0;
      key_latency(idx, 1'b0, lat);
      check_window($sformatf("key %0d press", idx), lat, debounce_cycles, debounce_cycles + 3);
      repeat (int'(key_hold) - lat) @(posedge fpga_clk_50);
      key[idx] <= 1'b1;
      key_latency(idx, 1'b1, lat);
      check_window($sformatf("key %0d release", idx), lat, debounce_cycles,
                   debounce_cycles + 3);
      repeat (int'(key_hold) - lat) @(posedge fpga_clk_50);
      key_mask = '0;
    end
  endtask

  // ======================================================================
  // stimulus
  // ======================================================================
  initial
  begin
    int unsigned glitch_cycles;
    key_t        glitch_keys;
    int          g;
    int          k;

    seed_draw        = $urandom(92);
    hps_fpga_reset_n = 1'b0;
    key              = '1;   // all released
    sw               = '0;
    led_pio          = '0;
    reset_req        = '0;
    test_name        = "reset";
    key_mask         = '0;
    quiet_mask       = '1;
    assert_errors    = 0;
    check_errors     = 0;

    repeat (4) @(posedge fpga_clk_50);
    hps_fpga_reset_n <= 1'b1;
    @(negedge fpga_clk_50);
    check_value("heartbeat after reset", 0, int'(ledr[0]));

    test_name = "glitch rejection";
    for (g = 0; g < int'(n_glitch); g++)
    begin
      glitch_cycles = $urandom_range(12, 1);   // always below debounce_cycles
      glitch_keys   = key_t'($urandom_range(15, 1));
      @(posedge fpga_clk_50);
      key <= ~glitch_keys;
      repeat (glitch_cycles) @(posedge fpga_clk_50);
      key <= '1;
      repeat (glitch_gap) @(posedge fpga_clk_50);
    end

    test_name = "debounced press and release";
    for (k = 0; k < int'(key_w); k++)
    begin
      press_and_release(k);
    end

    test_name = "reset pulse widths";
    pulse_one("cold", req_cold, cold_pulse_len);
    pulse_one("warm", req_warm, warm_pulse_len);
    pulse_one("debug", req_debug, debug_pulse_len);

    test_name  = "busy retrigger";
    quiet_mask = 3'b011;
    @(posedge fpga_clk_50);
    reset_req[req_debug] <= 1'b1;
    fork
      expect_pulse("debug retrigger", req_debug, debug_pulse_len);
      begin
        repeat (4) @(posedge fpga_clk_50);
        reset_req[req_debug] <= 1'b0;
        repeat (6) @(posedge fpga_clk_50);
        reset_req[req_debug] <= 1'b1;   // second edge lands 10 cycles into the pulse
      end
    join
    expect_idle("debug held after pulse", req_debug, 8);
    @(posedge fpga_clk_50);
    reset_req[req_debug] <= 1'b0;
    repeat (2) @(posedge fpga_clk_50);
    reset_req[req_debug] <= 1'b1;
    expect_pulse("debug fresh edge", req_debug, debug_pulse_len);
    @(posedge fpga_clk_50);
    reset_req[req_debug] <= 1'b0;

    test_name  = "request held through reset";
    quiet_mask = 3'b110;
    @(posedge fpga_clk_50);
    hps_fpga_reset_n     <= 1'b0;
    reset_req[req_cold]  <= 1'b1;
    repeat (4) @(posedge fpga_clk_50);
    hps_fpga_reset_n <= 1'b1;
    expect_pulse("cold after release", req_cold, cold_pulse_len);
    expect_idle("cold still held", req_cold, 40);   // no second pulse
    @(posedge fpga_clk_50);
    reset_req[req_cold] <= 1'b0;
    quiet_mask = '1;

    test_name = "event word and led bar";
    key_mask  = 4'b1010;
    @(posedge fpga_clk_50);
    key <= 4'b0101;   // keys 1 and 3 pressed
    repeat (key_hold) @(posedge fpga_clk_50);
    @(negedge fpga_clk_50);
    check_value("keys before event word", 4'b0101, int'(debounced_keys));
    repeat (n_event)
    begin
      @(posedge fpga_clk_50);
      sw      <= sw_t'($urandom());
      led_pio <= led_pio_t'($urandom());
    end
    @(posedge fpga_clk_50);
    key <= '1;
    repeat (key_hold) @(posedge fpga_clk_50);
    key_mask = '0;

    repeat (4) @(posedge fpga_clk_50);
    $display("errors: %0d from assertions, %0d from checks", assert_errors, check_errors);
    if (assert_errors == 0 && check_errors == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

  // ======================================================================
  // watchdog
  // ======================================================================
  initial
  begin
    repeat (watchdog_cycles) @(posedge fpga_clk_50);
    $display("run did not finish within %0d cycles, stopped by the watchdog", watchdog_cycles);
    $display("errors: %0d from assertions, %0d from checks", assert_errors, check_errors);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: verilog/fpga_glue_top.sv
// fabric glue logic for the SoC board top level
// debounces the push keys, stretches the three reset requests towards the
// processor, blinks the heartbeat LED and builds the trace event word
// timing parameters pass down to the blocks, defaults are board values
`timescale 1ns/1ps

module fpga_glue_top #(
  parameter int unsigned debounce_cycles   = board_pkg::debounce_cycles_default,
  parameter int unsigned blink_half_period = board_pkg::blink_half_period_default
) (
  input  logic                      fpga_clk_50,
  input  logic                      hps_fpga_reset_n,   // processor fabric reset
  input  board_pkg::key_t           key,                // active low
  input  board_pkg::sw_t            sw,
  input  board_pkg::led_pio_t       led_pio,            // processor LED register
  input  hps_reset_pkg::reset_req_t reset_req,          // cold, warm, debug
  output board_pkg::led_t           ledr,
  output board_pkg::stm_events_t    stm_hw_events,
  output board_pkg::key_t           debounced_keys,
  output logic                      cold_reset_req_n,
  output logic                      warm_reset_req_n,
  output logic                      debug_reset_req_n
);

  import board_pkg::*;
  import hps_reset_pkg::*;

  logic cold_pulse;
  logic warm_pulse;
  logic debug_pulse;
  logic heartbeat_led;

  // ====================================================================
  // push keys
  // ====================================================================
  key_debounce #(
    .width           ($bits(key_t)),
    .debounce_cycles (debounce_cycles)
  ) key_debounce_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key_in           (key),
    .key_out          (debounced_keys)
  );

  // ====================================================================
  // reset requests to the processor
  // ====================================================================
  reset_pulse_stretch #(
    .pulse_len (cold_pulse_len)
  ) cold_stretch_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[req_cold]),
    .pulse            (cold_pulse)
  );

  reset_pulse_stretch #(
    .pulse_len (warm_pulse_len)
  ) warm_stretch_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[req_warm]),
    .pulse            (warm_pulse)
  );

  reset_pulse_stretch #(
    .pulse_len (debug_pulse_len)
  ) debug_stretch_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[req_debug]),
    .pulse            (debug_pulse)
  );

  // processor side wants active-low requests
  assign cold_reset_req_n  = ~cold_pulse;
  assign warm_reset_req_n  = ~warm_pulse;
  assign debug_reset_req_n = ~debug_pulse;

  // ====================================================================
  // LEDs and trace events
  // ====================================================================
  heartbeat #(
    .half_period (blink_half_period)
  ) heartbeat_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led              (heartbeat_led)
  );

  assign ledr = {led_pio, heartbeat_led};   // bit 0 is the heartbeat

  // zero fill, switches, processor LEDs, keys at the bottom
  assign stm_hw_events = {{stm_pad_bits{1'b0}}, sw, led_pio, debounced_keys};

endmodule

// File: verilog/heartbeat.sv
// heartbeat blinker for the LED bar
// free-running counter wraps every half_period cycles and flips the LED
// LED starts dark after reset, first flip half_period cycles later
`timescale 1ns/1ps

module heartbeat #(
  parameter int unsigned half_period = board_pkg::blink_half_period_default
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic led
);

  // counter width, at least one bit
  localparam int unsigned cnt_w =
    ($clog2(half_period) > 0) ? $clog2(half_period) : 1;
  localparam logic [cnt_w-1:0] cnt_wrap = cnt_w'(half_period - 1);

  logic [cnt_w-1:0] cnt_q;

  // ====================================================================
  // divider
  // ====================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt_q <= '0;
      led   <= 1'b0;
    end
    else if (cnt_q == cnt_wrap)
    begin
      cnt_q <= '0;
      led   <= ~led;   // one phase done
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

// File: verilog/reset_pulse_stretch.sv
// turns the rising edge of one request bit into a fixed-length pulse
// pulse rises on the clock after the edge and lasts pulse_len cycles
// further edges while the pulse runs are dropped, not queued
// the history flop clears in reset, so a request held through reset
// gives one pulse once reset is released
`timescale 1ns/1ps

module reset_pulse_stretch #(
  parameter int unsigned pulse_len
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic req,    // level request, same clock domain
  output logic pulse   // active-high stretched pulse
);

  import hps_reset_pkg::*;

  localparam pulse_cnt_t cnt_load = pulse_cnt_t'(pulse_len - 1);

  stretch_state_t state_q;
  pulse_cnt_t     cnt_q;   // cycles left after the current one
  logic           req_q;   // req one cycle ago
  logic           req_rise;

  assign req_rise = req & ~req_q;

  // ====================================================================
  // edge history
  // ====================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_q <= 1'b0;   // held request counts as an edge after reset
    end
    else
    begin
      req_q <= req;    // tracks req in both states
    end
  end

  // ====================================================================
  // stretcher FSM
  // ====================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state_q <= idle;
      cnt_q   <= '0;
    end
    else
    begin
      case (state_q)
        idle:
        begin
          if (req_rise)
          begin
            state_q <= busy;
            cnt_q   <= cnt_load;
          end
        end
        busy:
        begin
          if (cnt_q == '0)
          begin
            state_q <= idle;        // last pulse cycle done
          end
          else
          begin
            cnt_q <= cnt_q - 1'b1;  // req ignored here
          end
        end
        default:
        begin
          state_q <= idle;
        end
      endcase
    end
  end

  assign pulse = (state_q == busy);  // straight from the state flop

endmodule

// File: verilog/key_debounce.sv
// debouncer for the active-low push keys
// each key goes through a two-flop synchronizer, then a per-key counter
// that accepts a new level only after it held for debounce_cycles clocks
// outputs come out of reset as all ones, i.e. released
`timescale 1ns/1ps

module key_debounce #(
  parameter int unsigned width           = 4,
  parameter int unsigned debounce_cycles = board_pkg::debounce_cycles_default
) (
  input  logic             fpga_clk_50,
  input  logic             hps_fpga_reset_n,
  input  logic [width-1:0] key_in,   // raw pins, asynchronous
  output logic [width-1:0] key_out   // clean level, 1 = released
);

  // counter width, at least one bit
  localparam int unsigned cnt_w =
    ($clog2(debounce_cycles) > 0) ? $clog2(debounce_cycles) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(debounce_cycles - 1);

  logic [width-1:0] meta_q;           // first sync stage
  logic [width-1:0] sync_q;           // second sync stage
  logic [cnt_w-1:0] cnt_q [width];    // stable-mismatch count per key

  // ====================================================================
  // synchronizer
  // ====================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      meta_q <= '1;  // keys idle high
      sync_q <= '1;
    end
    else
    begin
      meta_q <= key_in;
      sync_q <= meta_q;
    end
  end

  // ====================================================================
  // per-key filter
  // ====================================================================
  // counter runs only while sync differs from out
  // any match in between starts the count over
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_out <= '1;
      for (int i = 0; i < width; i++)
      begin
        cnt_q[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < width; i++)
      begin
        if (sync_q[i] == key_out[i])
        begin
          cnt_q[i] <= '0;            // level agrees, nothing pending
        end
        else if (cnt_q[i] == cnt_last)
        begin
          key_out[i] <= sync_q[i];   // held long enough, take it
          cnt_q[i]   <= '0;
        end
        else
        begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

endmodule

// File: verilog/hps_reset_pkg.sv
// reset request definitions for the fabric-to-processor reset lines
// three request bits feed three pulse stretchers, one per reset kind
// pulse lengths are in fpga_clk_50 cycles
package hps_reset_pkg;

  // request vector layout
  typedef logic [2:0] reset_req_t;

  localparam int unsigned req_cold  = 0;
  localparam int unsigned req_warm  = 1;
  localparam int unsigned req_debug = 2;

  // pulse length per request kind
  localparam int unsigned cold_pulse_len  = 6;
  localparam int unsigned warm_pulse_len  = 2;
  localparam int unsigned debug_pulse_len = 32;  // longest, sizes the counter

  // stretcher down counter, holds debug_pulse_len-1
  typedef logic [5:0] pulse_cnt_t;

  // stretcher FSM
  typedef enum logic {
    idle,  // waiting for a rising edge
    busy   // pulse out, edges ignored
  } stretch_state_t;

endpackage

// File: verilog/board_pkg.sv
// board-level widths and default timings for the fabric glue logic
// covers the push keys, slide switches, LED bar and the trace event word
// modules pull the defaults in as parameter values, simulation overrides them
package board_pkg;

  // ====================================================================
  // pin group widths
  // ====================================================================
  localparam int unsigned key_w     = 4;   // push keys, active low
  localparam int unsigned sw_w      = 10;  // slide switches
  localparam int unsigned led_w     = 10;  // LED bar
  localparam int unsigned led_pio_w = 9;   // processor-driven LED register
  localparam int unsigned stm_w     = 28;  // trace event word into the processor

  typedef logic [key_w-1:0]     key_t;
  typedef logic [sw_w-1:0]      sw_t;
  typedef logic [led_w-1:0]     led_t;
  typedef logic [led_pio_w-1:0] led_pio_t;
  typedef logic [stm_w-1:0]     stm_events_t;

  // zero fill above the payload in the event word
  // payload is sw, led_pio and the debounced keys
  localparam int unsigned stm_pad_bits = stm_w - sw_w - led_pio_w - key_w;

  // ====================================================================
  // clock and default timings
  // ====================================================================
  localparam int unsigned clk_freq_hz = 32'd50_000_000;  // fpga_clk_50

  // 1 ms of stable level before a key change is accepted
  localparam int unsigned debounce_cycles_default = clk_freq_hz / 1000;

  // half a second per LED phase, so 1 Hz blink
  localparam int unsigned blink_half_period_default = clk_freq_hz / 2;

endpackage
